// File: hw/lcd_pkg.sv
package lcd_pkg;

    ////////////////////
    // screen geometry and board widths.

    localparam int LINE_CHARS      = 16;  // characters on one panel line.
    localparam int SWITCH_COUNT    = 18;
    localparam int BANK_ADDR_WIDTH = 4;
    localparam int DATA_WIDTH      = 16;  // four hex digits per master word.
    localparam int MASTER_COUNT    = 2;

    ////////////////////
    // text types.

    // one character code, ascii compatible on the panel.
    typedef logic [7:0] char_t;

    // leftmost character sits in the top byte, so a 16 char string literal
    // drops straight into a line.
    typedef char_t [LINE_CHARS-1:0] screen_line_t;

    ////////////////////
    // menu states of the board controller.

    typedef enum logic [3:0] {
        master_slave_sel        = 4'd0,
        read_write_sel          = 4'd1,
        external_write_sel      = 4'd2,
        external_write_m1       = 4'd3,
        external_write_m1_2     = 4'd4,  // second pass of the m1 write.
        external_write_m2       = 4'd5,
        slave_start_addr_sel_m1 = 4'd6,
        slave_start_addr_sel_m2 = 4'd7,
        slave_end_addr_sel_m1   = 4'd8,
        slave_end_addr_sel_m2   = 4'd9,
        config_masters          = 4'd10,
        communication_ready     = 4'd11,
        communicating           = 4'd12,
        communication_done      = 4'd13
    } menu_state_t;

endpackage

// File: hw/lcd_screen_composer.sv
`timescale 1ns/1ps

module lcd_screen_composer (
    input  logic                                 clk,
    input  logic                                 rstN,
    input  lcd_pkg::menu_state_t                 state,
    input  logic [lcd_pkg::SWITCH_COUNT-1:0]     sw,
    input  logic [lcd_pkg::BANK_ADDR_WIDTH-1:0]  bank_addr,
    input  logic [lcd_pkg::DATA_WIDTH-1:0]       master_data [lcd_pkg::MASTER_COUNT],
    output lcd_pkg::screen_line_t                line_1,
    output lcd_pkg::screen_line_t                line_2
);

    localparam lcd_pkg::char_t        ARROW = 8'h7E;  // right arrow in the panel rom.
    localparam lcd_pkg::screen_line_t BLANK = {lcd_pkg::LINE_CHARS{8'h20}};

    logic [31:0]           sw_hex;
    logic [31:0]           m1_hex;
    logic [31:0]           m2_hex;
    lcd_pkg::char_t        addr_hex;
    lcd_pkg::screen_line_t line_1_next;
    lcd_pkg::screen_line_t line_2_next;

    ////////////////////
    // field formatting.

    function automatic lcd_pkg::char_t hex_char(input logic [3:0] value);
        lcd_pkg::char_t ch;
        if (value < 4'd10) begin
            ch = 8'h30 + 8'(value);
        end else begin
            ch = 8'h37 + 8'(value);  // 10 lands on 'A'.
        end
        return ch;
    endfunction

    function automatic logic [31:0] hex_word(input logic [15:0] value);
        return {hex_char(value[15:12]), hex_char(value[11:8]),
                hex_char(value[7:4]), hex_char(value[3:0])};
    endfunction

    function automatic lcd_pkg::char_t slave_char(input logic [1:0] value);
        lcd_pkg::char_t ch;
        case (value)
            2'b00:   ch = "_";  // no slave picked yet.
            2'b01:   ch = "1";
            2'b10:   ch = "2";
            default: ch = "3";
        endcase
        return ch;
    endfunction

    function automatic lcd_pkg::char_t op_char(input logic value);
        return value ? "W" : "R";
    endfunction

    function automatic lcd_pkg::char_t decision_char(input logic value);
        return value ? "y" : "n";
    endfunction

    assign sw_hex   = hex_word(sw[15:0]);
    assign m1_hex   = hex_word(master_data[0]);
    assign m2_hex   = hex_word(master_data[1]);
    assign addr_hex = hex_char(bank_addr);

    ////////////////////
    // text per menu state.

    always_comb begin
        line_1_next = line_1;  // states without a heading keep the old one.
        line_2_next = BLANK;
        case (state)
            lcd_pkg::master_slave_sel: begin
                line_1_next = "Master slave sel";
                line_2_next = {"M1 ", ARROW, " S", slave_char(sw[1:0]),
                               "  M2 ", ARROW, " S", slave_char(sw[3:2])};
            end
            lcd_pkg::read_write_sel: begin
                line_1_next = "Read write sel  ";
                line_2_next = {"M1 - ", op_char(sw[0]), "  M2 - ", op_char(sw[1]), "  "};
            end
            lcd_pkg::external_write_sel: begin
                line_1_next = "External write? ";
                line_2_next = {"M1 - ", decision_char(sw[0]),
                               "  M2 - ", decision_char(sw[1]), "  "};
            end
            lcd_pkg::external_write_m1,
            lcd_pkg::external_write_m1_2: begin
                line_1_next = "Ext. write M1   ";
                line_2_next = {"Addr-", addr_hex, " Val-", sw_hex, " "};
            end
            lcd_pkg::external_write_m2: begin
                line_1_next = "Ext. write M2   ";
                line_2_next = {"Addr-", addr_hex, " Val-", sw_hex, " "};
            end
            lcd_pkg::slave_start_addr_sel_m1: begin
                line_1_next = "M1 slave address";
                line_2_next = {"Start addr: ", sw_hex[23:0], " "};
            end
            lcd_pkg::slave_start_addr_sel_m2: begin
                line_1_next = "M2 slave address";
                line_2_next = {"Start addr: ", sw_hex[23:0], " "};
            end
            lcd_pkg::slave_end_addr_sel_m1: begin
                line_1_next = "M1 slave address";
                line_2_next = {"End addr: ", sw_hex[23:0], "   "};
            end
            lcd_pkg::slave_end_addr_sel_m2: begin
                line_1_next = "M2 slave address";
                line_2_next = {"End addr: ", sw_hex[23:0], "   "};
            end
            lcd_pkg::config_masters:      line_1_next = "Configure master";
            lcd_pkg::communication_ready: line_1_next = "Com. ready      ";
            lcd_pkg::communicating:       line_1_next = "Communicating...";
            lcd_pkg::communication_done: begin
                line_1_next = {"Mstr. addr. ", sw_hex[23:0], " "};
                line_2_next = {"M1-", m1_hex, " M2-", m2_hex, " "};
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            line_1 <= BLANK;
            line_2 <= BLANK;
        end else begin
            line_1 <= line_1_next;
            line_2 <= line_2_next;
        end
    end

endmodule

// File: hw/lcd_refresh_control.sv
`timescale 1ns/1ps

module lcd_refresh_control (
    input  logic                                 clk,
    input  logic                                 rstN,
    input  lcd_pkg::menu_state_t                 state,
    input  logic [lcd_pkg::SWITCH_COUNT-1:0]     sw,
    input  logic [lcd_pkg::BANK_ADDR_WIDTH-1:0]  bank_addr,
    input  logic [lcd_pkg::BANK_ADDR_WIDTH-1:0]  bank_addr_next,
    input  logic                                 ready,
    output logic                                 new_data
);

    lcd_pkg::menu_state_t                state_q;
    logic [lcd_pkg::SWITCH_COUNT-1:0]    sw_q;
    logic                                first_shown;
    logic                                pending;
    logic                                change;
    logic                                issue;

    // any input that alters the text, plus the very first frame.
    assign change = (state != state_q) || (sw != sw_q) ||
                    (bank_addr != bank_addr_next) || !first_shown;

    // skip the cycle of our own pulse since ready only drops after it.
    assign issue = pending && ready && !new_data;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            state_q     <= lcd_pkg::master_slave_sel;
            sw_q        <= '0;
            first_shown <= 1'b0;
            pending     <= 1'b0;
            new_data    <= 1'b0;
        end else begin
            state_q     <= state;
            sw_q        <= sw;
            first_shown <= 1'b1;
            new_data    <= issue;
            pending     <= change || (pending && !issue);  // a fresh change wins.
        end
    end

endmodule

// File: hw/lcd_write_sequencer.sv
`timescale 1ns/1ps

module lcd_write_sequencer #(
    parameter int ENABLE_CYCLES = 16,
    parameter int WAIT_CYCLES   = 20000
) (
    input  logic                  clk,
    input  logic                  rstN,
    input  logic                  new_data,
    input  lcd_pkg::screen_line_t line_1,
    input  lcd_pkg::screen_line_t line_2,
    output logic                  ready,
    output logic [7:0]            lcd_data,
    output logic                  lcd_rs,
    output logic                  lcd_en,
    output logic                  lcd_rw,
    output logic                  lcd_on,
    output logic                  lcd_blon
);

    localparam lcd_pkg::char_t CMD_FUNCTION_SET = 8'h38;  // 8 bit bus, 2 lines.
    localparam lcd_pkg::char_t CMD_DISPLAY_ON   = 8'h0C;  // no cursor, no blink.
    localparam lcd_pkg::char_t CMD_CLEAR        = 8'h01;
    localparam lcd_pkg::char_t CMD_ENTRY_MODE   = 8'h06;
    localparam lcd_pkg::char_t CMD_LINE_1       = 8'h80;
    localparam lcd_pkg::char_t CMD_LINE_2       = 8'hC0;

    localparam int INIT_BYTES  = 4;
    localparam int FRAME_BYTES = 2 * lcd_pkg::LINE_CHARS + 2;
    localparam int CNT_W       = $clog2(4 * WAIT_CYCLES + ENABLE_CYCLES + 1);

    typedef enum logic [1:0] {
        s_idle,
        s_setup,
        s_enable,
        s_wait
    } seq_state_t;

    seq_state_t            seq_state;
    logic [5:0]            byte_idx;
    logic                  init_phase;
    logic [CNT_W-1:0]      cnt;
    logic                  power_on;
    lcd_pkg::screen_line_t line_1_q;
    lcd_pkg::screen_line_t line_2_q;
    lcd_pkg::char_t        byte_data;
    logic                  byte_rs;
    logic                  last_byte;
    logic                  is_clear;

    ////////////////////
    // byte on the bus for the current index.

    always_comb begin
        byte_rs   = 1'b0;
        byte_data = CMD_LINE_1;
        if (init_phase) begin
            case (byte_idx[1:0])
                2'd0:    byte_data = CMD_FUNCTION_SET;
                2'd1:    byte_data = CMD_DISPLAY_ON;
                2'd2:    byte_data = CMD_CLEAR;
                default: byte_data = CMD_ENTRY_MODE;
            endcase
        end else if (byte_idx == 6'd0) begin
            byte_data = CMD_LINE_1;
        end else if (byte_idx <= 6'(lcd_pkg::LINE_CHARS)) begin
            byte_rs   = 1'b1;
            byte_data = line_1_q[4'(lcd_pkg::LINE_CHARS - byte_idx)];
        end else if (byte_idx == 6'(lcd_pkg::LINE_CHARS + 1)) begin
            byte_data = CMD_LINE_2;
        end else begin
            byte_rs   = 1'b1;
            byte_data = line_2_q[4'(FRAME_BYTES - 1 - byte_idx)];
        end
    end

    assign last_byte = init_phase ? (byte_idx == 6'(INIT_BYTES - 1))
                                  : (byte_idx == 6'(FRAME_BYTES - 1));
    assign is_clear  = init_phase && (byte_idx == 6'd2);  // clear needs the long wait.

    ////////////////////
    // setup, enable pulse, wait per byte.

    always_ff @(posedge clk) begin
        if (!rstN) begin
            seq_state  <= s_setup;
            byte_idx   <= '0;
            init_phase <= 1'b1;
            cnt        <= '0;
            power_on   <= 1'b0;
        end else begin
            power_on <= 1'b1;
            case (seq_state)
                s_idle: begin
                    if (new_data) begin
                        byte_idx  <= '0;
                        seq_state <= s_setup;
                    end
                end
                s_setup: begin
                    cnt       <= CNT_W'(ENABLE_CYCLES - 1);
                    seq_state <= s_enable;
                end
                s_enable: begin
                    if (cnt == '0) begin
                        cnt       <= is_clear ? CNT_W'(4 * WAIT_CYCLES - 1)
                                              : CNT_W'(WAIT_CYCLES - 1);
                        seq_state <= s_wait;
                    end else begin
                        cnt <= cnt - 1'b1;
                    end
                end
                s_wait: begin
                    if (cnt != '0) begin
                        cnt <= cnt - 1'b1;
                    end else if (last_byte) begin
                        init_phase <= 1'b0;
                        seq_state  <= s_idle;
                    end else begin
                        byte_idx  <= byte_idx + 1'b1;
                        seq_state <= s_setup;
                    end
                end
                default: seq_state <= s_idle;
            endcase
        end
    end

    // frame text is frozen at the request.
    always_ff @(posedge clk) begin
        if (seq_state == s_idle && new_data) begin
            line_1_q <= line_1;
            line_2_q <= line_2;
        end
    end

    assign ready    = (seq_state == s_idle);
    assign lcd_en   = (seq_state == s_enable);
    assign lcd_data = byte_data;
    assign lcd_rs   = byte_rs;
    assign lcd_rw   = 1'b0;  // write only.
    assign lcd_on   = power_on;
    assign lcd_blon = power_on;

endmodule

// File: hw/lcd_display_top.sv
`timescale 1ns/1ps

module lcd_display_top #(
    parameter int ENABLE_CYCLES = 16,
    parameter int WAIT_CYCLES   = 20000
) (
    input  logic                                 clk,
    input  logic                                 rstN,
    input  lcd_pkg::menu_state_t                 state,
    input  logic [lcd_pkg::SWITCH_COUNT-1:0]     sw,
    input  logic [lcd_pkg::BANK_ADDR_WIDTH-1:0]  bank_addr,
    input  logic [lcd_pkg::BANK_ADDR_WIDTH-1:0]  bank_addr_next,
    input  logic [lcd_pkg::DATA_WIDTH-1:0]       master_data [lcd_pkg::MASTER_COUNT],
    output logic [7:0]                           lcd_data,
    output logic                                 lcd_rw,
    output logic                                 lcd_en,
    output logic                                 lcd_rs,
    output logic                                 lcd_blon,
    output logic                                 lcd_on
);

    lcd_pkg::screen_line_t line_1;
    lcd_pkg::screen_line_t line_2;
    logic                  new_data;
    logic                  ready;

    lcd_screen_composer u_composer (
        .clk, .rstN, .state, .sw, .bank_addr, .master_data, .line_1, .line_2
    );

    lcd_refresh_control u_refresh (
        .clk, .rstN, .state, .sw, .bank_addr, .bank_addr_next, .ready, .new_data
    );

    lcd_write_sequencer #(
        .ENABLE_CYCLES(ENABLE_CYCLES),
        .WAIT_CYCLES  (WAIT_CYCLES)
    ) u_sequencer (
        .clk, .rstN, .new_data, .line_1, .line_2, .ready,
        .lcd_data, .lcd_rs, .lcd_en, .lcd_rw, .lcd_on, .lcd_blon
    );

endmodule

// File: bench/lcd_ref.svh
`ifndef LCD_REF_SVH
`define LCD_REF_SVH

////////////////////
// expected panel text.

function automatic string hex_text(input logic [15:0] value, input int digits);
    string digit_set;
    string text;
    int    d;
    digit_set = "0123456789ABCDEF";
    text      = "";
    for (int i = digits - 1; i >= 0; i--) begin
        d    = (value >> (4 * i)) & 15;
        text = {text, digit_set.substr(d, d)};
    end
    return text;
endfunction

function automatic string slave_text(input logic [1:0] value);
    string slave_set;
    slave_set = "_123";  // zero means no slave yet.
    return slave_set.substr(value, value);
endfunction

// short text is padded with spaces on the right.
function automatic lcd_pkg::screen_line_t text_line(input string text);
    lcd_pkg::screen_line_t line;
    for (int i = 0; i < lcd_pkg::LINE_CHARS; i++) begin
        line[lcd_pkg::LINE_CHARS - 1 - i] = (i < text.len()) ? text[i] : 8'h20;
    end
    return line;
endfunction

function automatic void reference_screen(
    input  lcd_pkg::menu_state_t  st,
    input  logic [17:0]           s,
    input  logic [3:0]            ba,
    input  logic [15:0]           d1,
    input  logic [15:0]           d2,
    output lcd_pkg::screen_line_t l1,
    output lcd_pkg::screen_line_t l2
);
    string t1;
    string t2;
    string addr;
    addr = hex_text(s[11:0], 3);  // address fields show three digits.
    t2   = "";
    case (st)
        lcd_pkg::master_slave_sel: begin
            t1 = "Master slave sel";
            t2 = $sformatf("M1 %c S%s  M2 %c S%s", 8'h7E, slave_text(s[1:0]),
                           8'h7E, slave_text(s[3:2]));
        end
        lcd_pkg::read_write_sel: begin
            t1 = "Read write sel";
            t2 = $sformatf("M1 - %c  M2 - %c", s[0] ? "W" : "R", s[1] ? "W" : "R");
        end
        lcd_pkg::external_write_sel: begin
            t1 = "External write?";
            t2 = $sformatf("M1 - %c  M2 - %c", s[0] ? "y" : "n", s[1] ? "y" : "n");
        end
        lcd_pkg::external_write_m1, lcd_pkg::external_write_m1_2,
        lcd_pkg::external_write_m2: begin
            t1 = (st == lcd_pkg::external_write_m2) ? "Ext. write M2" : "Ext. write M1";
            t2 = $sformatf("Addr-%s Val-%s", hex_text(ba, 1), hex_text(s[15:0], 4));
        end
        lcd_pkg::slave_start_addr_sel_m1: begin
            t1 = "M1 slave address";
            t2 = {"Start addr: ", addr};
        end
        lcd_pkg::slave_start_addr_sel_m2: begin
            t1 = "M2 slave address";
            t2 = {"Start addr: ", addr};
        end
        lcd_pkg::slave_end_addr_sel_m1: begin
            t1 = "M1 slave address";
            t2 = {"End addr: ", addr};
        end
        lcd_pkg::slave_end_addr_sel_m2: begin
            t1 = "M2 slave address";
            t2 = {"End addr: ", addr};
        end
        lcd_pkg::config_masters:      t1 = "Configure master";
        lcd_pkg::communication_ready: t1 = "Com. ready";
        lcd_pkg::communicating:       t1 = "Communicating...";
        lcd_pkg::communication_done: begin
            t1 = {"Mstr. addr. ", addr};
            t2 = $sformatf("M1-%s M2-%s", hex_text(d1, 4), hex_text(d2, 4));
        end
        default: t1 = "";
    endcase
    l1 = text_line(t1);
    l2 = text_line(t2);
endfunction

function automatic logic [31:0] xorshift32(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
endfunction

`endif

// File: bench/lcd_tb.sv
`timescale 1ns/1ps

module lcd_tb;

    localparam int ENABLE_CYCLES = 2;
    localparam int WAIT_CYCLES   = 3;
    localparam int FRAME_BYTES   = 2 * lcd_pkg::LINE_CHARS + 2;
    localparam int FRAME_CYCLES  = FRAME_BYTES * (1 + ENABLE_CYCLES + WAIT_CYCLES) + 4;
    localparam int WATCHDOG_NS   = 40 * FRAME_CYCLES * 10 + 2000;  // margin for reset and init.
    localparam logic [7:0] INIT_CMDS [4] = '{8'h38, 8'h0C, 8'h01, 8'h06};

    logic                  clk;
    logic                  rstN;
    lcd_pkg::menu_state_t  state;
    logic [17:0]           sw;
    logic [3:0]            bank_addr;
    logic [3:0]            bank_addr_next;
    logic [15:0]           master_data [2];
    logic [7:0]            lcd_data;
    logic                  lcd_rw;
    logic                  lcd_en;
    logic                  lcd_rs;
    logic                  lcd_blon;
    logic                  lcd_on;

    logic [31:0]           rng_state = 32'hc1fb0c29;
    int                    char_errors = 0;
    int                    cmd_errors = 0;
    int                    other_errors = 0;
    int                    frames_seen = 0;
    int                    frames_expected = 0;
    lcd_pkg::screen_line_t got_line_1 [$];
    lcd_pkg::screen_line_t got_line_2 [$];
    logic [15:0]           got_cmds [$];
    lcd_pkg::screen_line_t exp_line_1 [$];
    lcd_pkg::screen_line_t exp_line_2 [$];
    event                  frame_done;

    `include "lcd_ref.svh"

    lcd_display_top #(
        .ENABLE_CYCLES(ENABLE_CYCLES),
        .WAIT_CYCLES  (WAIT_CYCLES)
    ) UUT (
        .clk, .rstN, .state, .sw, .bank_addr, .bank_addr_next, .master_data,
        .lcd_data, .lcd_rw, .lcd_en, .lcd_rs, .lcd_blon, .lcd_on
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    ////////////////////
    // helpers.

    function automatic logic [31:0] draw();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    task automatic check_char(input string name, input int pos,
                              input lcd_pkg::char_t got, input lcd_pkg::char_t exp);
        if (got !== exp) begin
            char_errors++;
            $display("Error at %0t ns: %s pos %0d got 8'h%02h expected 8'h%02h",
                     $time, name, pos, got, exp);
        end
    endtask

    task automatic check_cmd(input string name, input int pos,
                             input logic [7:0] got, input logic [7:0] exp);
        if (got !== exp) begin
            cmd_errors++;
            $display("Error at %0t ns: %s byte %0d got 8'h%02h expected 8'h%02h",
                     $time, name, pos, got, exp);
        end
    endtask

    task automatic check_control(input int pos, input logic exp_rs);
        if (lcd_rs !== exp_rs || lcd_rw !== 1'b0) begin
            other_errors++;
            $display("Error at %0t ns: lcd_rs/lcd_rw byte %0d got %b/%b expected %b/0",
                     $time, pos, lcd_rs, lcd_rw, exp_rs);
        end
    endtask

    task automatic load_random(input lcd_pkg::menu_state_t st);
        logic [31:0] r1;
        logic [31:0] r2;
        r1             = draw();
        r2             = draw();
        state          = st;
        sw             = r1[17:0];
        bank_addr      = r1[31:28];
        bank_addr_next = r1[31:28];
        master_data[0] = r2[15:0];
        master_data[1] = r2[31:16];
    endtask

    task automatic expect_current();
        lcd_pkg::screen_line_t l1;
        lcd_pkg::screen_line_t l2;
        reference_screen(state, sw, bank_addr, master_data[0], master_data[1], l1, l2);
        exp_line_1.push_back(l1);
        exp_line_2.push_back(l2);
        frames_expected++;
    endtask

    task automatic wait_frames(input int target);
        int waited = 0;
        while (frames_seen < target && waited < 3 * FRAME_CYCLES) begin
            @(posedge clk);
            waited++;
        end
        if (frames_seen < target) begin
            other_errors++;
            $display("frame %0d was never written to the panel", target);
        end
    endtask

    // one latched bank write that shows the next address for a cycle.
    task automatic bank_update(input lcd_pkg::menu_state_t st);
        @(negedge clk);
        load_random(st);
        expect_current();
        wait_frames(frames_expected);
        @(negedge clk);
        bank_addr_next = bank_addr + 4'd1;
        @(negedge clk);
        bank_addr = bank_addr_next;
        expect_current();
        wait_frames(frames_expected);
    endtask

    ////////////////////
    // lcd bus monitor and frame compare.

    initial begin
        int                    idx;
        lcd_pkg::screen_line_t l1;
        lcd_pkg::screen_line_t l2;
        logic [7:0]            c1;
        logic [7:0]            c2;
        idx = 0;
        wait (rstN === 1'b1);
        for (int i = 0; i < 4; i++) begin
            @(negedge lcd_en);
            check_cmd("init lcd_data", i, lcd_data, INIT_CMDS[i]);
            check_control(i, 1'b0);
        end
        forever begin
            @(negedge lcd_en);
            check_control(idx, !(idx == 0 || idx == lcd_pkg::LINE_CHARS + 1));
            if (idx == 0) c1 = lcd_data;
            else if (idx == lcd_pkg::LINE_CHARS + 1) c2 = lcd_data;
            else if (idx <= lcd_pkg::LINE_CHARS) l1[lcd_pkg::LINE_CHARS - idx] = lcd_data;
            else l2[FRAME_BYTES - 1 - idx] = lcd_data;
            idx++;
            if (idx == FRAME_BYTES) begin
                got_line_1.push_back(l1);
                got_line_2.push_back(l2);
                got_cmds.push_back({c1, c2});
                idx = 0;
                -> frame_done;
            end
        end
    end

    initial begin
        lcd_pkg::screen_line_t g1;
        lcd_pkg::screen_line_t g2;
        lcd_pkg::screen_line_t e1;
        lcd_pkg::screen_line_t e2;
        logic [15:0]           gc;
        forever begin
            @(frame_done);
            while (got_line_1.size() > 0) begin
                g1 = got_line_1.pop_front();
                g2 = got_line_2.pop_front();
                gc = got_cmds.pop_front();
                if (exp_line_1.size() == 0) begin
                    other_errors++;
                    $display("an extra frame was written at %0t ns with no change to cause it",
                             $time);
                end else begin
                    e1 = exp_line_1.pop_front();
                    e2 = exp_line_2.pop_front();
                    check_cmd("frame lcd_data", 0, gc[15:8], 8'h80);
                    check_cmd("frame lcd_data", 17, gc[7:0], 8'hC0);
                    for (int i = 0; i < lcd_pkg::LINE_CHARS; i++) begin
                        check_char("line_1", i, g1[15 - i], e1[15 - i]);
                        check_char("line_2", i, g2[15 - i], e2[15 - i]);
                    end
                end
                frames_seen++;
            end
        end
    end

    ////////////////////
    // stimulus.

    initial begin
        logic [31:0] r;
        rstN = 1'b0;
        load_random(lcd_pkg::master_slave_sel);  // switches held through reset.
        expect_current();
        repeat (16) @(negedge clk);
        rstN = 1'b1;
        wait_frames(1);
        if (lcd_on !== 1'b1) begin
            other_errors++;
            $display("Error at %0t ns: lcd_on got %b expected 1", $time, lcd_on);
        end
        if (lcd_blon !== 1'b1) begin
            other_errors++;
            $display("Error at %0t ns: lcd_blon got %b expected 1", $time, lcd_blon);
        end

        for (int i = 1; i <= 14; i++) begin  // ends back in master_slave_sel.
            @(negedge clk);
            load_random(lcd_pkg::menu_state_t'(i % 14));
            expect_current();
            wait_frames(frames_expected);
        end

        repeat (2) begin
            @(negedge clk);
            r  = draw();
            sw = r[17:0];
            expect_current();
            wait_frames(frames_expected);
        end
        repeat (3 * FRAME_CYCLES) @(negedge clk);  // steady inputs, no frame.

        bank_update(lcd_pkg::external_write_m1);
        bank_update(lcd_pkg::external_write_m2);

        @(negedge clk);
        load_random(lcd_pkg::external_write_sel);
        expect_current();
        @(negedge lcd_en);
        repeat (4) begin
            repeat (9) @(negedge clk);
            r = draw();
            load_random(lcd_pkg::menu_state_t'(r % 14));
        end
        expect_current();
        wait_frames(frames_expected);
        repeat (FRAME_CYCLES) @(negedge clk);

        $display("errors: characters %0d, commands %0d, other %0d",
                 char_errors, cmd_errors, other_errors);
        if (char_errors + cmd_errors + other_errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog timeout, the test sequence did not finish in time");
        $display("RESULT: FAIL");
        $finish;
    end

endmodule

// File: src.f
+incdir+bench
hw/lcd_pkg.sv
hw/lcd_screen_composer.sv
hw/lcd_refresh_control.sv
hw/lcd_write_sequencer.sv
hw/lcd_display_top.sv
bench/lcd_tb.sv

// File: Bender.yml
package:
  name: lcd_display

sources:
  - files:
      - hw/lcd_pkg.sv
      - hw/lcd_screen_composer.sv
      - hw/lcd_refresh_control.sv
      - hw/lcd_write_sequencer.sv
      - hw/lcd_display_top.sv
  - target: test
    include_dirs:
      - bench
    files:
      - bench/lcd_tb.sv
